// ==== sources.f ====
+incdir+tests
hw/trs_io_pkg.sv
hw/spi_byte_slave.sv
hw/cmd_parser.sv
hw/cmd_exec.sv
hw/flash_spi_master.sv
hw/trs_io_top.sv
tests/tb_trs_io.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_trs_io
FILELIST  = sources.f
PASS_MSG  = test passed
BIN       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# exit status comes from the search for the pass line
run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== tests/tb_spi_host.svh ====
// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step per bit taken
task automatic rand_byte(output trs_io_pkg::byte_t b);
  int i;
  b = '0;
  for (i = 0; i < 8; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    b = {b[6:0], lfsr_state[0]};
  end
endtask

// one byte per cs frame, each sck level held 4 clocks
task automatic xfer_byte(input trs_io_pkg::byte_t tx, output trs_io_pkg::byte_t rx);
  int i;
  rx = '0;
  spi_cs_n <= 1'b0;
  spi_sck  <= 1'b0;
  repeat (4) @(posedge clk);
  for (i = 0; i < 8; i++) begin
    spi_sck  <= 1'b0;
    spi_mosi <= tx[7-i];
    repeat (4) @(posedge clk);
    // miso moves on falling edges, first bit after the first fall
    if (i > 0) begin
      rx[8-i] = spi_miso;
    end
    spi_sck <= 1'b1;
    repeat (4) @(posedge clk);
  end
  spi_sck <= 1'b0;
  repeat (4) @(posedge clk);
  rx[0] = spi_miso;
  spi_cs_n <= 1'b1;
  repeat (4) @(posedge clk);
endtask

task automatic check_byte(input string name, input trs_io_pkg::byte_t act,
                          input trs_io_pkg::byte_t exp);
  if (act !== exp) begin
    $display("ERR %0t %s: got %h, expected %h", $time, name, act, exp);
    err_cnt++;
  end
endtask

task automatic check_led(input string name, input trs_io_pkg::led_t act,
                         input trs_io_pkg::led_t exp);
  if (act !== exp) begin
    $display("ERR %0t %s: got %b, expected %b", $time, name, act, exp);
    err_cnt++;
  end
endtask

task automatic check_rgb(input string name, input trs_io_pkg::rgb_t act,
                         input trs_io_pkg::rgb_t exp);
  if (act !== exp) begin
    $display("ERR %0t %s: got %h, expected %h", $time, name, act, exp);
    err_cnt++;
  end
endtask

task automatic check_bit(input string name, input logic act, input logic exp);
  if (act !== exp) begin
    $display("ERR %0t %s: got %b, expected %b", $time, name, act, exp);
    err_cnt++;
  end
endtask

// ==== tests/tb_trs_io.sv ====
`timescale 1ns/1ps

module tb_trs_io;

  localparam int NUM_ROWS = 15;
  // five transfers of up to 80 clocks per row
  localparam int WATCHDOG_NS = NUM_ROWS * 5 * 80 * 10;

  typedef enum logic [3:0] {
    k_reset, k_led, k_esp, k_vpr, k_color, k_cs, k_resp, k_flash, k_error
  } check_e;

  typedef struct packed {
    check_e      kind;
    logic [3:0]  conf;
    logic [2:0]  nbytes;
    logic [31:0] bytes;   // first byte in [31:24]
    logic [23:0] exp;
  } row_t;

  logic                    clk;
  logic                    cass_out_sel_n;
  logic                    spi_cs_n;
  logic                    spi_sck;
  logic                    spi_mosi;
  logic [3:0]              conf;
  logic                    flash_so;
  logic                    spi_miso;
  trs_io_pkg::led_t        led;
  trs_io_pkg::byte_t       esp_status;
  logic                    vprinter_en;
  trs_io_pkg::rgb_t        screen_color;
  trs_io_pkg::flash_pins_t flash_pins;
  logic                    cmd_error;

  row_t        rows [NUM_ROWS];
  string       row_names [NUM_ROWS];
  int          row_cnt;
  int          err_cnt;
  int          fail_cnt;
  logic [31:0] lfsr_state;

  trs_io_top #(.FLASH_DIV_LOG2(3)) dut0 (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .spi_cs_n       (spi_cs_n),
    .spi_sck        (spi_sck),
    .spi_mosi       (spi_mosi),
    .conf           (conf),
    .flash_so       (flash_so),
    .spi_miso       (spi_miso),
    .led            (led),
    .esp_status     (esp_status),
    .vprinter_en    (vprinter_en),
    .screen_color   (screen_color),
    .flash          (flash_pins),
    .cmd_error      (cmd_error)
  );

  // flash so wired back to si
  assign flash_so = flash_pins.si;

  always #5 clk = ~clk;

  `include "tb_spi_host.svh"

  task automatic add_row(input check_e k, input logic [3:0] cf, input logic [2:0] n,
                         input logic [31:0] b, input logic [23:0] ex, input string name);
    rows[row_cnt] = '{kind: k, conf: cf, nbytes: n, bytes: b, exp: ex};
    row_names[row_cnt] = name;
    row_cnt++;
  endtask

  task automatic build_table();
    trs_io_pkg::byte_t p0;
    trs_io_pkg::byte_t p1;
    trs_io_pkg::byte_t p2;
    add_row(k_reset, 4'hf, 3'd0, 32'h0, 24'h0, "reset values");
    rand_byte(p0);
    // led is red, green, blue from p0 bits 0, 1, 2
    add_row(k_led, 4'hf, 3'd2, {8'd26, p0, 16'h0}, {21'h0, p0[0], p0[1], p0[2]}, "set_led");
    rand_byte(p0);
    add_row(k_esp, 4'hf, 3'd2, {8'd32, p0, 16'h0}, {16'h0, p0}, "set_esp_status");
    rand_byte(p0);
    add_row(k_vpr, 4'hf, 3'd2, {8'd33, p0, 16'h0}, {23'h0, p0[0]}, "set_vprinter_en");
    rand_byte(p0);
    rand_byte(p1);
    rand_byte(p2);
    add_row(k_color, 4'hf, 3'd4, {8'd17, p0, p1, p2}, {p0, p1, p2}, "set_screen_color");
    add_row(k_resp, 4'hf, 3'd1, {8'd0, 24'h0}, 24'h0000af, "get_cookie");
    add_row(k_resp, 4'hf, 3'd1, {8'd15, 24'h0}, 24'h000003, "get_version");
    // config reads back conf inverted
    // mode is 0011, plus 1000 while conf bit 3 is low
    add_row(k_resp, 4'h5, 3'd1, {8'd27, 24'h0}, 24'h00000a, "get_config conf 5");
    add_row(k_resp, 4'h5, 3'd1, {8'd16, 24'h0}, 24'h00000b, "get_mode conf 5");
    add_row(k_resp, 4'ha, 3'd1, {8'd27, 24'h0}, 24'h000005, "get_config conf a");
    add_row(k_resp, 4'ha, 3'd1, {8'd16, 24'h0}, 24'h000003, "get_mode conf a");
    add_row(k_cs, 4'hf, 3'd2, {8'd29, 8'h80, 16'h0}, 24'h0, "set_spi_ctrl_reg");
    rand_byte(p0);
    add_row(k_flash, 4'hf, 3'd2, {8'd30, p0, 16'h0}, {16'h0, p0}, "flash loopback");
    add_row(k_error, 4'hf, 3'd1, {8'd1, 24'h0}, 24'h1, "unknown opcode");
    rand_byte(p0);
    add_row(k_led, 4'hf, 3'd2, {8'd26, p0, 16'h0}, {21'h0, p0[0], p0[1], p0[2]},
            "set_led after error");
  endtask

  task automatic apply_row(input int idx);
    row_t              r;
    trs_io_pkg::byte_t rx;
    int                errs_before;
    int                i;
    logic              sck_prev;
    trs_io_pkg::byte_t sck_rises;
    r = rows[idx];
    errs_before = err_cnt;
    conf <= r.conf;
    for (i = 0; i < int'(r.nbytes); i++) begin
      xfer_byte(r.bytes[31 - 8*i -: 8], rx);
    end
    case (r.kind)
      k_reset: begin
        check_led("led", led, 3'b000);
        check_byte("esp_status", esp_status, 8'h00);
        check_bit("vprinter_en", vprinter_en, 1'b1);
        check_rgb("screen_color", screen_color, 24'hffffff);
        check_bit("cmd_error", cmd_error, 1'b0);
        check_bit("flash.cs_n", flash_pins.cs_n, 1'b1);
        check_bit("flash.sck", flash_pins.sck, 1'b0);
      end
      k_led:   check_led("led", led, trs_io_pkg::led_t'(r.exp[2:0]));
      k_esp:   check_byte("esp_status", esp_status, r.exp[7:0]);
      k_vpr:   check_bit("vprinter_en", vprinter_en, r.exp[0]);
      k_color: check_rgb("screen_color", screen_color, trs_io_pkg::rgb_t'(r.exp));
      k_cs:    check_bit("flash.cs_n", flash_pins.cs_n, r.exp[0]);
      k_resp: begin
        // response comes out during the next transfer
        xfer_byte(8'h00, rx);
        check_byte("spi_miso", rx, r.exp[7:0]);
      end
      k_flash: begin
        // 8 bits of 16 clocks each at FLASH_DIV_LOG2 3, one sck pulse per bit
        sck_prev  = flash_pins.sck;
        sck_rises = '0;
        repeat (136) begin
          @(posedge clk);
          if (flash_pins.sck && !sck_prev) begin
            sck_rises = sck_rises + 8'd1;
          end
          sck_prev = flash_pins.sck;
        end
        check_byte("flash.sck rises", sck_rises, 8'd8);
        check_bit("flash.sck", flash_pins.sck, 1'b0);
        xfer_byte(8'd31, rx);
        xfer_byte(8'h00, rx);
        check_byte("spi_miso", rx, r.exp[7:0]);
      end
      k_error: check_bit("cmd_error", cmd_error, 1'b1);
      default: begin
        $display("row %0d has an unknown check kind", idx);
        err_cnt++;
      end
    endcase
    if (err_cnt == errs_before) begin
      $display("test %0d %s: ok", idx, row_names[idx]);
    end else begin
      fail_cnt++;
      $display("test %0d %s: FAILED", idx, row_names[idx]);
    end
  endtask

  initial begin
    clk            = 1'b0;
    cass_out_sel_n = 1'b0;
    spi_cs_n       = 1'b1;
    spi_sck        = 1'b0;
    spi_mosi       = 1'b0;
    conf           = 4'hf;
    lfsr_state     = 32'ha183_5c3e;
    row_cnt        = 0;
    err_cnt        = 0;
    fail_cnt       = 0;
    build_table();
    repeat (2) @(posedge clk);
    cass_out_sel_n <= 1'b1;
    repeat (2) @(posedge clk);
    for (int t = 0; t < row_cnt; t++) begin
      apply_row(t);
    end
    $display("tests run %0d, failed %0d, errors %0d", row_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

endmodule

// ==== hw/trs_io_top.sv ====
`timescale 1ns/1ps

module trs_io_top #(
  parameter int FLASH_DIV_LOG2 = 3
) (
  input  logic                    clk,
  input  logic                    cass_out_sel_n,
  input  logic                    spi_cs_n,
  input  logic                    spi_sck,
  input  logic                    spi_mosi,
  input  logic [3:0]              conf,
  input  logic                    flash_so,
  output logic                    spi_miso,
  output trs_io_pkg::led_t        led,
  output trs_io_pkg::byte_t       esp_status,
  output logic                    vprinter_en,
  output trs_io_pkg::rgb_t        screen_color,
  output trs_io_pkg::flash_pins_t flash,
  output logic                    cmd_error
);

  trs_io_pkg::byte_t    rx_byte;
  logic                 rx_valid;
  trs_io_pkg::byte_t    tx_byte;
  trs_io_pkg::cmd_req_t cmd;
  logic                 cmd_valid;
  logic                 flash_ctrl_wr;
  logic                 flash_data_wr;
  trs_io_pkg::byte_t    flash_wr_byte;
  trs_io_pkg::byte_t    flash_rd;

  // host link
  spi_byte_slave spi0 (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .spi_cs_n       (spi_cs_n),
    .spi_sck        (spi_sck),
    .spi_mosi       (spi_mosi),
    .spi_miso       (spi_miso),
    .tx_byte        (tx_byte),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid)
  );

  cmd_parser parse0 (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid),
    .cmd            (cmd),
    .cmd_valid      (cmd_valid)
  );

  cmd_exec exec0 (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cmd            (cmd),
    .cmd_valid      (cmd_valid),
    .conf           (conf),
    .flash_rd       (flash_rd),
    .tx_byte        (tx_byte),
    .led            (led),
    .esp_status     (esp_status),
    .vprinter_en    (vprinter_en),
    .screen_color   (screen_color),
    .flash_ctrl_wr  (flash_ctrl_wr),
    .flash_data_wr  (flash_data_wr),
    .flash_wr_byte  (flash_wr_byte),
    .cmd_error      (cmd_error)
  );

  // busy has no consumer on the board, the host paces itself
  flash_spi_master #(
    .FLASH_DIV_LOG2 (FLASH_DIV_LOG2)
  ) flash0 (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .ctrl_wr        (flash_ctrl_wr),
    .data_wr        (flash_data_wr),
    .wr_byte        (flash_wr_byte),
    .flash_so       (flash_so),
    .rd_byte        (flash_rd),
    .busy           (),
    .flash          (flash)
  );

endmodule

// ==== hw/flash_spi_master.sv ====
`timescale 1ns/1ps

module flash_spi_master #(
  parameter int FLASH_DIV_LOG2 = 3
) (
  input  logic                    clk,
  input  logic                    cass_out_sel_n,
  input  logic                    ctrl_wr,
  input  logic                    data_wr,
  input  trs_io_pkg::byte_t       wr_byte,
  input  logic                    flash_so,
  output trs_io_pkg::byte_t       rd_byte,
  output logic                    busy,
  output trs_io_pkg::flash_pins_t flash
);

  // run bit, 3 bit index, sck phase, divider
  localparam int CNT_W = FLASH_DIV_LOG2 + 5;

  logic [CNT_W-1:0]  cnt;
  logic              cs_en;
  logic              si_q;
  logic              half_start;
  trs_io_pkg::byte_t shift;

  assign half_start = (cnt[FLASH_DIV_LOG2-1:0] == '0);
  assign busy       = cnt[CNT_W-1];

  // control register, only bit 7 (chip select) is implemented
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      cs_en <= 1'b0;
    end else if (ctrl_wr) begin
      cs_en <= wr_byte[7];
    end
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      cnt  <= '0;
      si_q <= 1'b0;
    end else if (busy) begin
      // wraps to zero after the eighth bit, clearing the run bit
      cnt <= cnt + CNT_W'(1);
      if (half_start && !cnt[FLASH_DIV_LOG2]) begin
        si_q <= shift[7];
      end
    end else if (data_wr) begin
      cnt <= {1'b1, {(CNT_W-1){1'b0}}};
    end
  end

  always_ff @(posedge clk) begin
    if (busy) begin
      // sample so at the start of the high half
      if (half_start && cnt[FLASH_DIV_LOG2]) begin
        shift <= {shift[6:0], flash_so};
      end
    end else if (data_wr) begin
      shift <= wr_byte;
    end
  end

  assign rd_byte = shift;
  assign flash   = '{cs_n: ~cs_en, sck: cnt[FLASH_DIV_LOG2], si: si_q};

  // host must wait out a transfer before writing the next byte
  a_no_write_while_busy : assert property (
    @(posedge clk) disable iff (!cass_out_sel_n) data_wr |-> !busy
  );

endmodule

// ==== hw/cmd_exec.sv ====
`timescale 1ns/1ps

module cmd_exec (
  input  logic                 clk,
  input  logic                 cass_out_sel_n,
  input  trs_io_pkg::cmd_req_t cmd,
  input  logic                 cmd_valid,
  input  logic [3:0]           conf,
  input  trs_io_pkg::byte_t    flash_rd,
  output trs_io_pkg::byte_t    tx_byte,
  output trs_io_pkg::led_t     led,
  output trs_io_pkg::byte_t    esp_status,
  output logic                 vprinter_en,
  output trs_io_pkg::rgb_t     screen_color,
  output logic                 flash_ctrl_wr,
  output logic                 flash_data_wr,
  output trs_io_pkg::byte_t    flash_wr_byte,
  output logic                 cmd_error
);

  logic [3:0] mode_bits;

  // dip 4 off adds bit 3 to the mode
  assign mode_bits = trs_io_pkg::MODE_BASE | {~conf[3], 3'b000};

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      tx_byte       <= '0;
      led           <= '0;
      esp_status    <= '0;
      vprinter_en   <= 1'b1;
      screen_color  <= trs_io_pkg::SCREEN_COLOR_RESET;
      flash_ctrl_wr <= 1'b0;
      flash_data_wr <= 1'b0;
      cmd_error     <= 1'b0;
    end else begin
      flash_ctrl_wr <= 1'b0;
      flash_data_wr <= 1'b0;
      if (cmd_valid) begin
        case (cmd.opcode)
          // board registers
          trs_io_pkg::set_led: begin
            led <= '{red: cmd.p0[0], green: cmd.p0[1], blue: cmd.p0[2]};
          end
          trs_io_pkg::set_esp_status:   esp_status <= cmd.p0;
          trs_io_pkg::set_vprinter_en:  vprinter_en <= cmd.p0[0];
          trs_io_pkg::set_screen_color: begin
            screen_color <= '{red: cmd.p0, green: cmd.p1, blue: cmd.p2};
          end
          // flash master strobes
          trs_io_pkg::set_spi_ctrl_reg: flash_ctrl_wr <= 1'b1;
          trs_io_pkg::set_spi_data:     flash_data_wr <= 1'b1;
          // responses, read out in the next transfer
          trs_io_pkg::get_cookie:   tx_byte <= trs_io_pkg::COOKIE;
          trs_io_pkg::get_version:  tx_byte <= trs_io_pkg::VERSION_BYTE;
          trs_io_pkg::get_config:   tx_byte <= {4'b0000, ~conf};
          trs_io_pkg::get_mode:     tx_byte <= {4'b0000, mode_bits};
          trs_io_pkg::get_spi_data: tx_byte <= flash_rd;
          // unknown opcode, flag stays set until reset
          default:                  cmd_error <= 1'b1;
        endcase
      end
    end
  end

  // data for either flash strobe
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      flash_wr_byte <= cmd.p0;
    end
  end

endmodule

// ==== hw/cmd_parser.sv ====
`timescale 1ns/1ps

module cmd_parser (
  input  logic                 clk,
  input  logic                 cass_out_sel_n,
  input  trs_io_pkg::byte_t    rx_byte,
  input  logic                 rx_valid,
  output trs_io_pkg::cmd_req_t cmd,
  output logic                 cmd_valid
);

  trs_io_pkg::parse_state_e state;
  trs_io_pkg::param_cnt_t   bytes_left;
  trs_io_pkg::param_cnt_t   param_idx;
  trs_io_pkg::param_cnt_t   op_params;

  // parameter bytes that follow each opcode
  function automatic trs_io_pkg::param_cnt_t param_count(trs_io_pkg::byte_t op);
    trs_io_pkg::param_cnt_t n;
    case (trs_io_pkg::opcode_e'(op))
      trs_io_pkg::set_screen_color: n = 2'd3;
      trs_io_pkg::set_led,
      trs_io_pkg::set_spi_ctrl_reg,
      trs_io_pkg::set_spi_data,
      trs_io_pkg::set_esp_status,
      trs_io_pkg::set_vprinter_en:  n = 2'd1;
      // get_ opcodes and anything unknown
      default:                      n = 2'd0;
    endcase
    return n;
  endfunction

  assign op_params = param_count(rx_byte);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state      <= trs_io_pkg::idle;
      bytes_left <= 2'd0;
      param_idx  <= 2'd0;
      cmd_valid  <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      if (rx_valid) begin
        case (state)
          trs_io_pkg::idle: begin
            param_idx <= 2'd0;
            if (op_params == 2'd0) begin
              cmd_valid <= 1'b1;
            end else begin
              bytes_left <= op_params;
              state      <= trs_io_pkg::read_bytes;
            end
          end
          trs_io_pkg::read_bytes: begin
            if (bytes_left == 2'd1) begin
              cmd_valid <= 1'b1;
              state     <= trs_io_pkg::idle;
            end else begin
              bytes_left <= bytes_left - 2'd1;
              param_idx  <= param_idx + 2'd1;
            end
          end
          default: state <= trs_io_pkg::idle;
        endcase
      end
    end
  end

  // command record, opcode latched in idle and params in arrival order
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      if (state == trs_io_pkg::idle) begin
        cmd.opcode <= trs_io_pkg::opcode_e'(rx_byte);
      end else begin
        case (param_idx)
          2'd0:    cmd.p0 <= rx_byte;
          2'd1:    cmd.p1 <= rx_byte;
          default: cmd.p2 <= rx_byte;
        endcase
      end
    end
  end

  // longest command carries three params, so the index stops at 2
  a_param_idx_range : assert property (
    @(posedge clk) disable iff (!cass_out_sel_n)
      (state == trs_io_pkg::read_bytes) |-> (param_idx <= 2'd2)
  );

endmodule

// ==== hw/spi_byte_slave.sv ====
`timescale 1ns/1ps

module spi_byte_slave (
  input  logic               clk,
  input  logic               cass_out_sel_n,
  input  logic               spi_cs_n,
  input  logic               spi_sck,
  input  logic               spi_mosi,
  output logic               spi_miso,
  input  trs_io_pkg::byte_t  tx_byte,
  output trs_io_pkg::byte_t  rx_byte,
  output logic               rx_valid
);

  logic [2:0]        sck_sync;
  logic [2:0]        cs_sync;
  logic [1:0]        mosi_sync;
  logic              sck_rise;
  logic              sck_fall;
  logic              cs_active;
  logic              cs_start;
  logic [2:0]        bit_cnt;
  trs_io_pkg::byte_t tx_shift;

  // synchronizers, idle levels on reset
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_sync  <= 3'b000;
      cs_sync   <= 3'b111;
      mosi_sync <= 2'b00;
    end else begin
      sck_sync  <= {sck_sync[1:0], spi_sck};
      cs_sync   <= {cs_sync[1:0], spi_cs_n};
      mosi_sync <= {mosi_sync[0], spi_mosi};
    end
  end

  assign sck_rise  = (sck_sync[2:1] == 2'b01);
  assign sck_fall  = (sck_sync[2:1] == 2'b10);
  assign cs_active = ~cs_sync[1];
  // falling edge of cs_n marks a new transfer
  assign cs_start  = (cs_sync[2:1] == 2'b10);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt  <= 3'd0;
      rx_valid <= 1'b0;
      tx_shift <= '0;
    end else begin
      rx_valid <= 1'b0;
      if (cs_start) begin
        // any partial byte is dropped here
        bit_cnt <= 3'd0;
      end else if (cs_active) begin
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) begin
            rx_valid <= 1'b1;
          end
        end
        if (sck_fall) begin
          // first falling edge of a byte picks up the new response
          if (bit_cnt == 3'd1) begin
            tx_shift <= tx_byte;
          end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
          end
        end
      end
    end
  end

  // receive shifter, msb first
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      rx_byte <= {rx_byte[6:0], mosi_sync[1]};
    end
  end

  assign spi_miso = cs_active ? tx_shift[7] : 1'b0;

  // a byte needs eight sck edges, so strobes can never be adjacent
  a_rx_valid_single : assert property (
    @(posedge clk) disable iff (!cass_out_sel_n) rx_valid |=> !rx_valid
  );

endmodule

// ==== hw/trs_io_pkg.sv ====
package trs_io_pkg;

  // one byte on the spi link
  typedef logic [7:0] byte_t;

  // number of parameter bytes behind an opcode, at most 3
  typedef logic [1:0] param_cnt_t;

  // host command opcodes, numbering kept from the board firmware
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    get_version      = 8'd15,
    get_mode         = 8'd16,
    set_screen_color = 8'd17,
    set_led          = 8'd26,
    get_config       = 8'd27,
    set_spi_ctrl_reg = 8'd29,
    set_spi_data     = 8'd30,
    get_spi_data     = 8'd31,
    set_esp_status   = 8'd32,
    set_vprinter_en  = 8'd33
  } opcode_e;

  // command parser states
  typedef enum logic {
    idle,
    read_bytes
  } parse_state_e;

  // opcode plus up to three parameter bytes
  typedef struct packed {
    opcode_e opcode;
    byte_t   p0;
    byte_t   p1;
    byte_t   p2;
  } cmd_req_t;

  typedef struct packed {
    byte_t red;
    byte_t green;
    byte_t blue;
  } rgb_t;

  typedef struct packed {
    logic red;
    logic green;
    logic blue;
  } led_t;

  // config flash pins
  typedef struct packed {
    logic cs_n;
    logic sck;
    logic si;
  } flash_pins_t;

  localparam byte_t COOKIE = 8'haf;

  // major in [7:5], minor in [4:0]
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;
  localparam byte_t VERSION_BYTE = {VERSION_MAJOR, VERSION_MINOR};

  localparam logic [3:0] MODE_BASE = 4'b0011;

  localparam rgb_t SCREEN_COLOR_RESET = '{red: 8'hff, green: 8'hff, blue: 8'hff};

endpackage
